// ==== filelist.f ====
logic/rv_pkg.sv
logic/core_ifs.sv
logic/reg_bank.sv
logic/imm_gen.sv
logic/decoder.sv
logic/alu.sv
logic/pc_unit.sv
logic/data_mem.sv
logic/core.sv
logic/rv_top.sv
testbench/rv_checker.sv
testbench/tb_rv_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_top -Mdir obj_dir -o sim -f filelist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1

// ==== testbench/tb_rv_top.sv ====
// Processor testbench
`timescale 1ns/1ps
`default_nettype none

module tb_rv_top;

	localparam logic [31:0] nop = 32'h0000_0013; // addi x0,x0,0
	localparam int max_cycles = 200;

	logic        clk = 1'b0;
	logic        arst_n;
	logic [31:0] idata;
	logic [9:0]  iaddr, daddr;
	logic [31:0] ddata_w;
	logic        mem_write, mem_read;

	// program table, one entry per word of the fetch space
	logic [31:0] prog [256];
	logic [9:0]  next_pc [256];
	logic        st_flag [256];
	logic        ld_flag [256];
	logic [9:0]  st_addr [256];
	logic [31:0] st_data [256];
	logic [63:0] names [256];

	logic [31:0] model_regs [32] = '{default: '0};
	logic [31:0] model_mem [256];
	logic [9:0]  asm_pc, end_pc;
	logic [31:0] va, vb, vc;
	integer      seed;
	int          slot, cycles, failures, mismatches, checks;

	always #5 clk = ~clk;

	rv_top i_dut (.clk(clk), .arst_n(arst_n), .idata(idata), .iaddr(iaddr), .daddr(daddr),
		.ddata_w(ddata_w), .mem_write(mem_write), .mem_read(mem_read));

	rv_checker i_checker (.clk(clk), .arst_n(arst_n), .iaddr(iaddr), .daddr(daddr),
		.ddata_w(ddata_w), .mem_write(mem_write), .mem_read(mem_read), .next_pc(next_pc),
		.st_flag(st_flag), .ld_flag(ld_flag), .st_addr(st_addr), .st_data(st_data),
		.names(names), .mismatches(mismatches), .checks(checks));

	// RV32I integer rules, alt selects sub and sra
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		logic [31:0] fill;
		logic [31:0] r;
		fill = a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0; // sign copies shifted in from the top
		case (f3)
			3'd0: r = alt ? a + ~b + 32'd1 : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b}; // negative one is less
			3'd4: r = a ^ b;
			3'd5: r = (a >> b[4:0]) | (alt ? fill : 32'd0);
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// records one instruction at the cursor and moves the cursor to its successor
	task automatic put(input logic [63:0] name, input logic [31:0] word, input logic [9:0] nxt,
		input logic st, input logic [9:0] sa, input logic [31:0] sd);
		logic [7:0] k;
		k = asm_pc[9:2];
		prog[k] = word;
		names[k] = name;
		next_pc[k] = nxt;
		st_flag[k] = st;
		ld_flag[k] = 1'b0;
		st_addr[k] = sa;
		st_data[k] = sd;
		asm_pc = nxt;
	endtask

	task automatic put_seq(input logic [63:0] name, input logic [31:0] word);
		put(name, word, asm_pc + 10'd4, 1'b0, '0, '0);
	endtask

	task automatic set_reg(input logic [4:0] rd, input logic [31:0] val);
		if (rd != 5'd0) begin
			model_regs[rd] = val; // x0 stays zero
		end
	endtask

	task automatic i_op(input logic [63:0] name, input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		logic alt;
		alt = (f3 == 3'd5) && imm[10];
		put_seq(name, {imm, rs1, f3, rd, rv_pkg::op_itype});
		set_reg(rd, alu_model(f3, alt, model_regs[rs1], {{20{imm[11]}}, imm}));
	endtask

	task automatic upper_op(input logic [63:0] name, input logic pc_rel, input logic [4:0] rd,
		input logic [19:0] imm20);
		logic [31:0] base;
		base = pc_rel ? {22'd0, asm_pc} : 32'd0;
		put_seq(name, {imm20, rd, pc_rel ? rv_pkg::op_auipc : rv_pkg::op_lui});
		set_reg(rd, base + {imm20, 12'd0});
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] up;
		up = value + 32'h800; // addi sign-extends its low twelve bits
		upper_op("lui", 1'b0, rd, up[31:12]);
		i_op("addi", 3'd0, rd, rd, value[11:0]);
	endtask

	task automatic store(input logic [63:0] name, input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] off);
		logic [31:0] ea;
		ea = model_regs[rs1] + {{20{off[11]}}, off};
		put(name, {off[11:5], rs2, rs1, 3'b010, off[4:0], rv_pkg::op_store}, asm_pc + 10'd4,
			1'b1, ea[9:0], model_regs[rs2]);
		model_mem[ea[9:2]] = model_regs[rs2];
	endtask

	task automatic load(input logic [63:0] name, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] off);
		logic [31:0] ea;
		logic [7:0]  k;
		ea = model_regs[rs1] + {{20{off[11]}}, off};
		k = asm_pc[9:2];
		put_seq(name, {off, rs1, 3'b010, rd, rv_pkg::op_load});
		ld_flag[k] = 1'b1; // only loads drive the read strobe
		set_reg(rd, model_mem[ea[9:2]]);
	endtask

	task automatic beq(input logic [63:0] name, input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [12:0] off);
		logic [9:0] nxt;
		nxt = (model_regs[rs1] == model_regs[rs2]) ? asm_pc + off[9:0] : asm_pc + 10'd4;
		put(name, {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], rv_pkg::op_branch},
			nxt, 1'b0, '0, '0);
	endtask

	// x3 carries every result out through its own store slot
	task automatic result_store(input logic [63:0] name);
		store(name, 5'd3, 5'd0, 12'(12'h100 + 4 * slot));
		slot++;
	endtask

	task automatic op_check(input logic [63:0] name, input logic alt, input logic [2:0] f3,
		input logic [4:0] rs1, input logic [4:0] rs2);
		put_seq(name, {1'b0, alt, 5'd0, rs2, rs1, f3, 5'd3, rv_pkg::op_rtype});
		set_reg(5'd3, alu_model(f3, alt, model_regs[rs1], model_regs[rs2]));
		result_store(name);
	endtask

	task automatic build_program();
		asm_pc = '0;
		repeat (256) put_seq("nop", nop); // cursor wraps back to zero
		slot = 0;
		load_const(5'd1, va);
		load_const(5'd2, vb);
		load_const(5'd4, vc);
		op_check("add", 1'b0, 3'd0, 5'd1, 5'd2);
		op_check("sub", 1'b1, 3'd0, 5'd1, 5'd2);
		op_check("and", 1'b0, 3'd7, 5'd1, 5'd2);
		op_check("or", 1'b0, 3'd6, 5'd1, 5'd2);
		op_check("xor", 1'b0, 3'd4, 5'd1, 5'd2);
		op_check("slt_nep", 1'b0, 3'd2, 5'd1, 5'd2);
		op_check("slt_pne", 1'b0, 3'd2, 5'd2, 5'd1);
		op_check("slt_nn", 1'b0, 3'd2, 5'd1, 5'd4);
		op_check("sll", 1'b0, 3'd1, 5'd1, 5'd2);
		op_check("srl", 1'b0, 3'd5, 5'd1, 5'd2);
		op_check("sra", 1'b1, 3'd5, 5'd4, 5'd2);
		i_op("srai", 3'd5, 5'd3, 5'd1, {7'b0100000, 5'd7});
		result_store("srai");
		i_op("xori", 3'd4, 5'd3, 5'd2, 12'h9a5);
		result_store("xori");
		store("sw", 5'd2, 5'd0, 12'h200);
		load("lw", 5'd6, 5'd0, 12'h200);
		store("lw", 5'd6, 5'd0, 12'h204);
		beq("beq_ne", 5'd1, 5'd2, 13'd8);
		beq("beq_eq", 5'd1, 5'd1, 13'd12);
		beq("beq_back", 5'd0, 5'd0, -13'd8);
		result_store("beq"); // reached only through the backward branch
		beq("beq_fwd", 5'd0, 5'd0, 13'd8);
		upper_op("auipc", 1'b1, 5'd3, 20'h00abc);
		result_store("auipc");
		i_op("x0", 3'd0, 5'd0, 5'd1, 12'h055);
		store("x0", 5'd0, 5'd0, 12'h2f0);
		end_pc = asm_pc;
	endtask

	initial begin
		seed = 32'h20ba36a7;
		arst_n = 1'b0;
		idata = nop;
		failures = 0;
		va = $random(seed) | 32'h8000_0000; // negative operands for the signed compares
		vb = $random(seed) & 32'h7fff_ffff;
		vc = $random(seed) | 32'h8000_0000;
		build_program();
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;
		idata = prog[iaddr[9:2]];
		cycles = 0;
		while (iaddr != end_pc && cycles < max_cycles) begin
			@(posedge clk);
			#1;
			idata = prog[iaddr[9:2]];
			cycles++;
		end
		if (iaddr != end_pc) begin
			$display("timeout: the program never reached its final address 0x%h", end_pc);
			failures++;
		end
		repeat (2) begin
			@(posedge clk);
			#1;
			idata = prog[iaddr[9:2]];
		end
		$display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0 && checks > 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/rv_checker.sv ====
// Processor bus checker
`timescale 1ns/1ps
`default_nettype none

module rv_checker (
	input  wire logic                       clk,
	input  wire logic                       arst_n,
	input  wire logic [rv_pkg::iaddr_w-1:0] iaddr,
	input  wire logic [rv_pkg::iaddr_w-1:0] daddr,
	input  wire logic [rv_pkg::xlen-1:0]    ddata_w,
	input  wire logic                       mem_write,
	input  wire logic                       mem_read,
	input  wire logic [rv_pkg::iaddr_w-1:0] next_pc [256],
	input  wire logic                       st_flag [256],
	input  wire logic                       ld_flag [256],
	input  wire logic [rv_pkg::iaddr_w-1:0] st_addr [256],
	input  wire logic [rv_pkg::xlen-1:0]    st_data [256],
	input  wire logic [63:0]                names [256],
	output int                              mismatches,
	output int                              checks
);

	logic [rv_pkg::iaddr_w-1:0] exp_pc = '0; // where the previous instruction should have sent fetch
	logic [7:0]                 prev = '0;
	logic [7:0]                 idx;
	int                         n_mismatch = 0;
	int                         n_check = 0;

	assign idx        = iaddr[9:2];
	assign mismatches = n_mismatch;
	assign checks     = n_check;

	// mid-cycle both the fetched word and the data bus have settled
	always @(negedge clk) begin
		if (arst_n) begin
			n_check++;
			if (iaddr !== exp_pc) begin
				$display("mismatch %s iaddr: expected 0x%h actual 0x%h", names[prev], exp_pc, iaddr);
				n_mismatch++;
			end
			if (mem_read !== ld_flag[idx]) begin
				$display("mismatch %s mem_read: expected %b actual %b", names[idx], ld_flag[idx],
					mem_read);
				n_mismatch++;
			end
			if (mem_write !== st_flag[idx]) begin
				$display("mismatch %s mem_write: expected %b actual %b", names[idx], st_flag[idx],
					mem_write);
				n_mismatch++;
			end else if (mem_write) begin
				n_check++;
				if (daddr !== st_addr[idx]) begin
					$display("mismatch %s daddr: expected 0x%h actual 0x%h", names[idx],
						st_addr[idx], daddr);
					n_mismatch++;
				end
				if (ddata_w !== st_data[idx]) begin
					$display("mismatch %s ddata_w: expected 0x%h actual 0x%h", names[idx],
						st_data[idx], ddata_w);
					n_mismatch++;
				end
			end
			prev   = idx;
			exp_pc = next_pc[idx]; // follow the served entry so one fault is not repeated
		end
	end

endmodule

`default_nettype wire

// ==== logic/rv_top.sv ====
// Processor top level
`timescale 1ns/1ps
`default_nettype none

module rv_top (
	input  wire logic                       clk,
	input  wire logic                       arst_n,
	input  wire logic [rv_pkg::xlen-1:0]    idata,
	output logic      [rv_pkg::iaddr_w-1:0] iaddr,
	output logic      [rv_pkg::iaddr_w-1:0] daddr,
	output logic      [rv_pkg::xlen-1:0]    ddata_w,
	output logic                            mem_write,
	output logic                            mem_read
);

	dmem_if bus ();

	core i_core (.clk(clk), .arst_n(arst_n), .idata(idata), .iaddr(iaddr),
		.dmem(bus.master));

	data_mem i_data_mem (.clk(clk), .bus(bus.slave));

	// the data bus stays visible at the pins for observation
	assign daddr     = bus.addr;
	assign ddata_w   = bus.wdata;
	assign mem_write = bus.write;
	assign mem_read  = bus.read;

endmodule

`default_nettype wire

// ==== logic/core.sv ====
// Single-cycle RV32I datapath
`timescale 1ns/1ps
`default_nettype none

module core (
	input  wire logic                       clk,
	input  wire logic                       arst_n,
	input  wire logic [rv_pkg::xlen-1:0]    idata,
	output logic      [rv_pkg::iaddr_w-1:0] iaddr,
	dmem_if.master                          dmem
);

	rv_pkg::instr_u          instr;
	logic [rv_pkg::xlen-1:0] rd1, rd2, imm;
	logic [rv_pkg::xlen-1:0] alu_a, alu_b, alu_result, wb_data;
	logic                    zero;
	logic                    take_branch;

	ctrl_if ctrl ();

	assign instr = idata;

	reg_bank i_reg_bank (.clk(clk), .arst_n(arst_n), .we(ctrl.reg_write),
		.ra1(instr.r_fmt.rs1), .ra2(instr.r_fmt.rs2), .wa(instr.r_fmt.rd),
		.wd(wb_data), .rd1(rd1), .rd2(rd2));

	imm_gen i_imm_gen (.instr(instr), .imm(imm));

	decoder i_decoder (.instr(instr), .ctrl(ctrl.source));

	always_comb begin
		case (ctrl.a_src)
			rv_pkg::asrc_pc:   alu_a = {{(rv_pkg::xlen-rv_pkg::iaddr_w){1'b0}}, iaddr}; // auipc
			rv_pkg::asrc_zero: alu_a = '0; // lui passes the immediate straight through
			default:           alu_a = rd1;
		endcase
	end

	assign alu_b = ctrl.alu_src_imm ? imm : rd2;

	alu i_alu (.a(alu_a), .b(alu_b), .op(ctrl.alu_op), .result(alu_result), .zero(zero));

	assign wb_data     = ctrl.mem_to_reg ? dmem.rdata : alu_result;
	assign take_branch = ctrl.branch & zero;

	pc_unit i_pc_unit (.clk(clk), .arst_n(arst_n), .imm(imm), .take_branch(take_branch),
		.pc(iaddr));

	assign dmem.addr  = alu_result[rv_pkg::iaddr_w-1:0]; // effective address from the ALU
	assign dmem.wdata = rd2;
	assign dmem.read  = ctrl.mem_read;
	assign dmem.write = ctrl.mem_write;

endmodule

`default_nettype wire

// ==== logic/data_mem.sv ====
// Data memory
`timescale 1ns/1ps
`default_nettype none

module data_mem (
	input wire logic clk,
	dmem_if.slave    bus
);

	logic [rv_pkg::xlen-1:0]    mem [rv_pkg::dmem_words];
	logic [rv_pkg::iaddr_w-3:0] word_idx;

	assign word_idx = bus.addr[rv_pkg::iaddr_w-1:2]; // byte offset is ignored

	always_ff @(posedge clk) begin
		if (bus.write) begin
			mem[word_idx] <= bus.wdata;
		end
	end

	assign bus.rdata = bus.read ? mem[word_idx] : '0; // bus idles at zero

	// the decoder never asks for a load and a store together
	rw_exclusive: assert property (@(posedge clk) !(bus.read && bus.write))
		else $error("data memory saw read and write in the same cycle");

endmodule

`default_nettype wire

// ==== logic/pc_unit.sv ====
// Program counter
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
	input  wire logic                       clk,
	input  wire logic                       arst_n,
	input  wire logic [rv_pkg::xlen-1:0]    imm,
	input  wire logic                       take_branch,
	output logic      [rv_pkg::iaddr_w-1:0] pc
);

	logic [rv_pkg::iaddr_w-1:0] pc_plus4;
	logic [rv_pkg::iaddr_w-1:0] pc_target;

	assign pc_plus4  = pc + {{(rv_pkg::iaddr_w-3){1'b0}}, 3'd4};
	assign pc_target = pc + imm[rv_pkg::iaddr_w-1:0]; // wraps inside the fetch space

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else begin
			pc <= take_branch ? pc_target : pc_plus4;
		end
	end

	// branch offsets from the decoder must keep fetch on word boundaries
	pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
		else $error("program counter left word alignment");

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire logic [rv_pkg::xlen-1:0] a,
	input  wire logic [rv_pkg::xlen-1:0] b,
	input  wire rv_pkg::alu_op_e         op,
	output logic      [rv_pkg::xlen-1:0] result,
	output logic                         zero
);

	logic [4:0] shamt;

	assign shamt = b[4:0]; // shifts only look at the low five bits

	always_comb begin
		case (op)
			rv_pkg::alu_add: result = a + b;
			rv_pkg::alu_sub: result = a - b;
			rv_pkg::alu_and: result = a & b;
			rv_pkg::alu_or:  result = a | b;
			rv_pkg::alu_xor: result = a ^ b;
			rv_pkg::alu_slt: begin
				result = {{(rv_pkg::xlen-1){1'b0}}, ($signed(a) < $signed(b))};
			end
			rv_pkg::alu_sll: result = a << shamt;
			rv_pkg::alu_srl: result = a >> shamt;
			rv_pkg::alu_sra: result = $unsigned($signed(a) >>> shamt); // sign bit fills in
			default:         result = '0;
		endcase
	end

	assign zero = (result == '0); // beq relies on this after a subtract

endmodule

`default_nettype wire

// ==== logic/decoder.sv ====
// Main and ALU control decode
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input wire rv_pkg::instr_u instr,
	ctrl_if.source             ctrl
);

	// funct3 picks the operation, alt selects sub or sra
	function automatic rv_pkg::alu_op_e funct_op(input logic [2:0] f3, input logic alt);
		rv_pkg::alu_op_e op;
		case (f3)
			3'b000:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001:  op = rv_pkg::alu_sll;
			3'b010:  op = rv_pkg::alu_slt;
			3'b100:  op = rv_pkg::alu_xor;
			3'b101:  op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110:  op = rv_pkg::alu_or;
			3'b111:  op = rv_pkg::alu_and;
			default: op = rv_pkg::alu_add; // sltu is outside the subset
		endcase
		return op;
	endfunction

	logic [2:0] funct3;
	logic       bit30;

	assign funct3 = instr.r_fmt.funct3;
	assign bit30  = instr.r_fmt.funct7[5];

	always_comb begin
		ctrl.branch      = 1'b0;
		ctrl.mem_read    = 1'b0;
		ctrl.mem_write   = 1'b0;
		ctrl.mem_to_reg  = 1'b0;
		ctrl.reg_write   = 1'b0;
		ctrl.alu_src_imm = 1'b0;
		ctrl.a_src       = rv_pkg::asrc_rs1;
		ctrl.alu_op      = rv_pkg::alu_add; // address math for loads, stores and upper immediates
		case (instr.r_fmt.opcode)
			rv_pkg::op_rtype: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = funct_op(funct3, bit30);
			end
			rv_pkg::op_itype: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = funct_op(funct3, (funct3 == 3'b101) && bit30); // addi has no subi
			end
			rv_pkg::op_load: begin
				ctrl.mem_read    = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			rv_pkg::op_store: begin
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			rv_pkg::op_branch: begin
				ctrl.branch = (funct3 == 3'b000); // only beq, taken on a zero difference
				ctrl.alu_op = rv_pkg::alu_sub;
			end
			rv_pkg::op_lui: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.a_src       = rv_pkg::asrc_zero;
			end
			rv_pkg::op_auipc: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.a_src       = rv_pkg::asrc_pc;
			end
			default: begin
				ctrl.reg_write = 1'b0; // unknown opcodes retire as a nop
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/imm_gen.sv ====
// Immediate generator
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
	input  wire rv_pkg::instr_u          instr,
	output logic [rv_pkg::xlen-1:0]      imm
);

	always_comb begin
		case (instr.r_fmt.opcode)
			rv_pkg::op_itype, rv_pkg::op_load: begin
				imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
			end
			rv_pkg::op_store: begin
				imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
			end
			rv_pkg::op_branch: begin // halfword offset, bit 0 is implied zero
				imm = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
					instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
			end
			rv_pkg::op_lui, rv_pkg::op_auipc: begin
				imm = {instr.u_fmt.imm, 12'd0}; // upper 20 bits, low part cleared
			end
			default: begin
				imm = '0; // R-type and anything unknown carry no immediate
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/reg_bank.sv ====
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
	input  wire logic                    clk,
	input  wire logic                    arst_n,
	input  wire logic                    we,
	input  wire logic [4:0]              ra1,
	input  wire logic [4:0]              ra2,
	input  wire logic [4:0]              wa,
	input  wire logic [rv_pkg::xlen-1:0] wd,
	output logic      [rv_pkg::xlen-1:0] rd1,
	output logic      [rv_pkg::xlen-1:0] rd2
);

	logic [rv_pkg::xlen-1:0] regs [32];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != 5'd0) begin // x0 never takes a write
			regs[wa] <= wd;
		end
	end

	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

	// a fetched instruction must never see an undefined operand
	rd1_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(rd1))
		else $error("reg_bank read port 1 returned an unknown value");

endmodule

`default_nettype wire

// ==== logic/core_ifs.sv ====
// Core internal interfaces
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;
	logic            branch;
	logic            mem_read;
	logic            mem_write;
	logic            mem_to_reg;
	logic            reg_write;
	logic            alu_src_imm;
	rv_pkg::asrc_e   a_src;
	rv_pkg::alu_op_e alu_op;

	modport source (output branch, mem_read, mem_write, mem_to_reg, reg_write,
		alu_src_imm, a_src, alu_op);
	modport sink (input branch, mem_read, mem_write, mem_to_reg, reg_write,
		alu_src_imm, a_src, alu_op);
endinterface

interface dmem_if;
	logic [rv_pkg::iaddr_w-1:0] addr;
	logic [rv_pkg::xlen-1:0]    wdata;
	logic [rv_pkg::xlen-1:0]    rdata; // valid in the same cycle as read
	logic                       read;
	logic                       write; // commits at the next rising edge

	modport master (output addr, wdata, read, write, input rdata);
	modport slave (input addr, wdata, read, write, output rdata);
endinterface

`default_nettype wire

// ==== logic/rv_pkg.sv ====
// RV32I core package
`default_nettype none

package rv_pkg;

	localparam int xlen       = 32;
	localparam int iaddr_w    = 10; // byte address over a 1024-byte space
	localparam int dmem_words = 256;

	// major opcodes of the supported subset
	localparam logic [6:0] op_rtype  = 7'b0110011;
	localparam logic [6:0] op_itype  = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_srl,
		alu_sra
	} alu_op_e;

	// first ALU operand, zero for lui and pc for auipc
	typedef enum logic [1:0] {
		asrc_rs1,
		asrc_pc,
		asrc_zero
	} asrc_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// one instruction word seen through every encoding
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
	} instr_u;

endpackage

`default_nettype wire
